//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = conv_layer_tb
FILELIST = conv_layer.f
OBJ_DIR  = obj_dir
PASS_MSG = all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- conv_layer.f
+incdir+include
logic/conv_pkg.sv
logic/window_if.sv
logic/window_fetch.sv
logic/row_mac.sv
logic/depth_accumulate.sv
logic/conv_layer.sv
verification/conv_layer_tb.sv

//--- include/conv_config.svh
`ifndef CONV_CONFIG_SVH
`define CONV_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// layer shape
////////////////////////////////////////////////////////////////////////////

`define CONV_DATA_WIDTH        16  // one fm / weight / bias word
`define CONV_KERNEL            3   // kernel side K
`define CONV_FM_SIZE           8   // input fm side
`define CONV_FM_DEPTH          4   // input depth slices
`define CONV_KERNEL_COUNT      2
`define CONV_STRIDE            1
`define CONV_OUT_SIZE          6   // (FM_SIZE - K) / STRIDE + 1

////////////////////////////////////////////////////////////////////////////
// datapath and memory widths
////////////////////////////////////////////////////////////////////////////

`define CONV_ACC_WIDTH         40  // wide enough for the sum over depth
`define CONV_LAYER_ADDR_WIDTH  19
`define CONV_WEIGHT_ADDR_WIDTH 10

`endif

//--- logic/conv_layer.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_layer (
    input  logic                    clk,
    input  logic                    convRst,
    input  logic                    start,
    input  conv_pkg::layer_addr_t   in_base,
    input  conv_pkg::layer_addr_t   out_base,
    output logic                    fm_rd_en,
    output conv_pkg::layer_addr_t   fm_rd_addr,
    input  conv_pkg::data_t         fm_rd_data,
    output logic                    wt_rd_en,
    output conv_pkg::weight_addr_t  wt_rd_addr,
    input  conv_pkg::weight_slice_u wt_rd_data,
    output logic                    bias_rd_en,
    output conv_pkg::weight_addr_t  bias_rd_addr,
    input  conv_pkg::data_t         bias_rd_data,
    output logic                    out_we,
    output conv_pkg::layer_addr_t   out_addr,
    output conv_pkg::data_t         out_data,
    output logic                    done
);
    import conv_pkg::*;

    localparam int OUT_TOTAL = `CONV_KERNEL_COUNT * `CONV_OUT_SIZE * `CONV_OUT_SIZE;

    window_if win ();

    logic                    fetch_busy;
    logic                    running;     // from accepted start to last write
    logic                    start_go;
    layer_addr_t             last_addr;
    acc_t [`CONV_KERNEL-1:0] row_sum;
    logic [`CONV_KERNEL-1:0] row_valid;

    assign start_go = start && !running && !fetch_busy;  // ignored while busy

    window_fetch i_window_fetch (
        .clk          (clk),
        .convRst      (convRst),
        .start        (start_go),
        .in_base      (in_base),
        .fm_rd_en     (fm_rd_en),
        .fm_rd_addr   (fm_rd_addr),
        .fm_rd_data   (fm_rd_data),
        .wt_rd_en     (wt_rd_en),
        .wt_rd_addr   (wt_rd_addr),
        .wt_rd_data   (wt_rd_data),
        .bias_rd_en   (bias_rd_en),
        .bias_rd_addr (bias_rd_addr),
        .bias_rd_data (bias_rd_data),
        .win          (win),
        .busy         (fetch_busy)
    );

    for (genvar r = 0; r < `CONV_KERNEL; r++) begin : g_lane
        row_mac #(.ROW(r)) i_row_mac (
            .clk       (clk),
            .convRst   (convRst),
            .win       (win),
            .row_sum   (row_sum[r]),
            .row_valid (row_valid[r])
        );
    end

    depth_accumulate i_depth_accumulate (
        .clk       (clk),
        .convRst   (convRst),
        .start     (start_go),
        .out_base  (out_base),
        .win       (win),
        .row_sum   (row_sum),
        .row_valid (row_valid),
        .out_we    (out_we),
        .out_addr  (out_addr),
        .out_data  (out_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // status
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            running <= 1'b0;
            done    <= 1'b0;
        end else if (start_go) begin
            running <= 1'b1;
            done    <= 1'b0;
        end else if (running && out_we && out_addr == last_addr) begin
            running <= 1'b0;  // final output written
            done    <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (start_go)
            last_addr <= out_base + layer_addr_t'(OUT_TOTAL - 1);
    end

endmodule

//--- logic/conv_pkg.sv
`include "conv_config.svh"

package conv_pkg;

    // signed fixed point words
    typedef logic signed [`CONV_DATA_WIDTH-1:0] data_t;
    typedef logic signed [`CONV_ACC_WIDTH-1:0]  acc_t;

    typedef logic [`CONV_LAYER_ADDR_WIDTH-1:0]  layer_addr_t;
    typedef logic [`CONV_WEIGHT_ADDR_WIDTH-1:0] weight_addr_t;

    // tap c sits at bits c*16 upward
    typedef data_t [`CONV_KERNEL-1:0] tap_row_t;

    // one weight RAM word holds a whole K x K slice
    typedef union packed {
        logic [`CONV_KERNEL*`CONV_KERNEL*`CONV_DATA_WIDTH-1:0] flat;  // raw RAM word
        tap_row_t [`CONV_KERNEL-1:0]                           rows;  // row r at r*48
    } weight_slice_u;

endpackage

//--- logic/depth_accumulate.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module depth_accumulate (
    input  logic                             clk,
    input  logic                             convRst,
    input  logic                             start,
    input  conv_pkg::layer_addr_t            out_base,
    window_if.accum                          win,
    input  conv_pkg::acc_t [`CONV_KERNEL-1:0] row_sum,
    input  logic [`CONV_KERNEL-1:0]          row_valid,
    output logic                             out_we,
    output conv_pkg::layer_addr_t            out_addr,
    output conv_pkg::data_t                  out_data
);
    import conv_pkg::*;

    localparam int   K         = `CONV_KERNEL;
    localparam int   OUT_TOTAL = `CONV_KERNEL_COUNT * `CONV_OUT_SIZE * `CONV_OUT_SIZE;
    localparam acc_t SAT_MAX   = acc_t'(2 ** (`CONV_DATA_WIDTH - 1) - 1);
    localparam acc_t SAT_MIN   = acc_t'(-(2 ** (`CONV_DATA_WIDTH - 1)));

    logic        first_q;
    logic        last_q;
    data_t       bias_q;
    acc_t        acc_q;
    acc_t        row_total;
    acc_t        depth_sum;
    acc_t        biased;
    data_t       sat_data;
    logic        write_now;
    layer_addr_t base_q;
    layer_addr_t out_cnt;

    always_comb begin
        row_total = '0;
        for (int r = 0; r < K; r++)
            row_total = row_total + row_sum[r];
    end

    assign depth_sum = first_q ? row_total : acc_q + row_total;  // restart on depth 0
    assign biased    = depth_sum + acc_t'(bias_q);
    assign write_now = row_valid[0] && last_q;

    // clamp to 16 bit signed
    always_comb begin
        if (biased > SAT_MAX)
            sat_data = data_t'(SAT_MAX);
        else if (biased < SAT_MIN)
            sat_data = data_t'(SAT_MIN);
        else
            sat_data = data_t'(biased);
    end

    ////////////////////////////////////////////////////////////////////////////
    // accumulate and write back
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            first_q <= 1'b0;
            last_q  <= 1'b0;
            out_we  <= 1'b0;
            out_cnt <= '0;
        end else begin
            first_q <= win.first_depth;
            last_q  <= win.last_depth;
            out_we  <= write_now;
            if (start)
                out_cnt <= '0;
            else if (write_now)
                out_cnt <= out_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        bias_q <= win.bias;
        if (start)
            base_q <= out_base;
        if (row_valid[0])
            acc_q <= depth_sum;
        if (write_now) begin
            out_addr <= base_q + out_cnt;
            out_data <= sat_data;
        end
    end

    // no more writes than the layer has outputs
    a_write_count: assert property (@(posedge clk) disable iff (convRst)
        write_now |-> out_cnt < layer_addr_t'(OUT_TOTAL));

endmodule

//--- logic/row_mac.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module row_mac #(
    parameter int ROW = 0  // kernel row served by this lane
) (
    input  logic           clk,
    input  logic           convRst,
    window_if.lane         win,
    output conv_pkg::acc_t row_sum,
    output logic           row_valid
);
    import conv_pkg::*;

    localparam int K = `CONV_KERNEL;

    acc_t sum_c;

    // sum of the K products of this row
    always_comb begin : row_dot
        data_t                                fm_tap;
        data_t                                wt_tap;
        logic signed [2*`CONV_DATA_WIDTH-1:0] prod;
        sum_c = '0;
        for (int c = 0; c < K; c++) begin
            fm_tap = win.fm_rows[ROW][c];
            wt_tap = win.weights.rows[ROW][c];
            prod   = fm_tap * wt_tap;        // 32 bit signed product
            sum_c  = sum_c + acc_t'(prod);
        end
    end

    always_ff @(posedge clk or posedge convRst) begin
        if (convRst)
            row_valid <= 1'b0;
        else
            row_valid <= win.win_valid;
    end

    always_ff @(posedge clk) begin
        if (win.win_valid)
            row_sum <= sum_c;
    end

endmodule

//--- logic/window_fetch.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module window_fetch (
    input  logic                    clk,
    input  logic                    convRst,
    input  logic                    start,
    input  conv_pkg::layer_addr_t   in_base,
    output logic                    fm_rd_en,
    output conv_pkg::layer_addr_t   fm_rd_addr,
    input  conv_pkg::data_t         fm_rd_data,
    output logic                    wt_rd_en,
    output conv_pkg::weight_addr_t  wt_rd_addr,
    input  conv_pkg::weight_slice_u wt_rd_data,
    output logic                    bias_rd_en,
    output conv_pkg::weight_addr_t  bias_rd_addr,
    input  conv_pkg::data_t         bias_rd_data,
    window_if.fetch                 win,
    output logic                    busy
);
    import conv_pkg::*;

    localparam int K       = `CONV_KERNEL;
    localparam int FM      = `CONV_FM_SIZE;
    localparam int FM_AREA = FM * FM;
    localparam int DEPTH   = `CONV_FM_DEPTH;
    localparam int OUT     = `CONV_OUT_SIZE;
    localparam int KCOUNT  = `CONV_KERNEL_COUNT;
    localparam int STRIDE  = `CONV_STRIDE;

    logic        active;
    logic        gap;         // spare slot after the last tap read
    logic [7:0]  ker_cnt;
    logic [7:0]  y_cnt;
    logic [7:0]  x_cnt;
    logic [7:0]  dep_cnt;
    logic [3:0]  r_cnt;       // tap row inside the window
    logic [3:0]  c_cnt;       // tap column
    logic [3:0]  r_q;
    logic [3:0]  c_q;
    logic        fm_pend;     // read data arrives this cycle
    logic        wt_pend;
    logic        bias_pend;
    logic        first_tap;
    logic        step_end;
    logic        layer_end;
    layer_addr_t in_base_q;

    assign first_tap = active && !gap && r_cnt == 0 && c_cnt == 0;
    assign step_end  = active && gap;
    assign layer_end = step_end && ker_cnt == KCOUNT - 1 && y_cnt == OUT - 1
                       && x_cnt == OUT - 1 && dep_cnt == DEPTH - 1;

    ////////////////////////////////////////////////////////////////////////////
    // read requests
    ////////////////////////////////////////////////////////////////////////////

    assign fm_rd_en   = active && !gap;
    assign fm_rd_addr = in_base_q
                        + layer_addr_t'(dep_cnt * FM_AREA)
                        + layer_addr_t'((y_cnt * STRIDE + r_cnt) * FM)
                        + layer_addr_t'(x_cnt * STRIDE + c_cnt);

    assign wt_rd_en     = first_tap;  // whole slice in one word
    assign wt_rd_addr   = weight_addr_t'(ker_cnt * DEPTH + dep_cnt);
    assign bias_rd_en   = first_tap && dep_cnt == 0 && y_cnt == 0 && x_cnt == 0;
    assign bias_rd_addr = weight_addr_t'(ker_cnt);

    assign busy = active;

    // nested loops kernel > y > x > depth > tap
    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            active  <= 1'b0;
            gap     <= 1'b0;
            ker_cnt <= '0;
            y_cnt   <= '0;
            x_cnt   <= '0;
            dep_cnt <= '0;
            r_cnt   <= '0;
            c_cnt   <= '0;
        end else if (start && !active) begin
            active  <= 1'b1;
            gap     <= 1'b0;
            ker_cnt <= '0;
            y_cnt   <= '0;
            x_cnt   <= '0;
            dep_cnt <= '0;
            r_cnt   <= '0;
            c_cnt   <= '0;
        end else if (active) begin
            if (!gap) begin
                if (c_cnt == K - 1) begin
                    c_cnt <= '0;
                    if (r_cnt == K - 1) begin
                        r_cnt <= '0;
                        gap   <= 1'b1;
                    end else begin
                        r_cnt <= r_cnt + 1'b1;
                    end
                end else begin
                    c_cnt <= c_cnt + 1'b1;
                end
            end else begin
                gap <= 1'b0;
                if (layer_end)
                    active <= 1'b0;
                if (dep_cnt == DEPTH - 1) begin
                    dep_cnt <= '0;
                    if (x_cnt == OUT - 1) begin
                        x_cnt <= '0;
                        if (y_cnt == OUT - 1) begin
                            y_cnt   <= '0;
                            ker_cnt <= ker_cnt + 1'b1;
                        end else begin
                            y_cnt <= y_cnt + 1'b1;
                        end
                    end else begin
                        x_cnt <= x_cnt + 1'b1;
                    end
                end else begin
                    dep_cnt <= dep_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // capture of returned words
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge convRst) begin
        if (convRst) begin
            fm_pend         <= 1'b0;
            wt_pend         <= 1'b0;
            bias_pend       <= 1'b0;
            win.win_valid   <= 1'b0;
            win.first_depth <= 1'b0;
            win.last_depth  <= 1'b0;
        end else begin
            fm_pend         <= fm_rd_en;
            wt_pend         <= wt_rd_en;
            bias_pend       <= bias_rd_en;
            win.win_valid   <= step_end;  // last tap landed this cycle
            win.first_depth <= dep_cnt == 0;
            win.last_depth  <= dep_cnt == DEPTH - 1;
        end
    end

    always_ff @(posedge clk) begin
        r_q <= r_cnt;
        c_q <= c_cnt;
        if (start && !active)
            in_base_q <= in_base;
        if (fm_pend)
            win.fm_rows[r_q][c_q] <= fm_rd_data;
        if (wt_pend)
            win.weights <= wt_rd_data;
        if (bias_pend)
            win.bias <= bias_rd_data;  // held for every step of the kernel
    end

    // every fm read stays inside the input map
    a_read_in_map: assert property (@(posedge clk) disable iff (convRst)
        fm_rd_en |-> layer_addr_t'(fm_rd_addr - in_base_q) < FM_AREA * DEPTH);

endmodule

//--- logic/window_if.sv
`timescale 1ns/100ps
`include "conv_config.svh"

interface window_if;
    import conv_pkg::*;

    logic                        win_valid;    // one cycle per complete window
    tap_row_t [`CONV_KERNEL-1:0] fm_rows;
    weight_slice_u               weights;
    data_t                       bias;         // bias of the current kernel
    logic                        first_depth;
    logic                        last_depth;

    modport fetch (
        output win_valid, fm_rows, weights, bias, first_depth, last_depth
    );

    modport lane (
        input win_valid, fm_rows, weights
    );

    modport accum (
        input win_valid, bias, first_depth, last_depth
    );

endinterface

//--- verification/conv_layer_tb.sv
`timescale 1ns/100ps
`include "conv_config.svh"

module conv_layer_tb;
    import conv_pkg::*;

    localparam int K          = `CONV_KERNEL;
    localparam int FM         = `CONV_FM_SIZE;
    localparam int D          = `CONV_FM_DEPTH;
    localparam int KC         = `CONV_KERNEL_COUNT;
    localparam int STRIDE     = `CONV_STRIDE;
    localparam int OUT        = `CONV_OUT_SIZE;
    localparam int FM_WORDS   = FM * FM * D;
    localparam int OUT_TOTAL  = KC * OUT * OUT;
    localparam int RUN_CYCLES = KC * OUT * OUT * D * (K * K + 1);
    localparam int CYCLE_LIMIT = 4 * 2 * RUN_CYCLES + 2000;  // four runs at twice nominal
    localparam longint SAT_MAX = 2 ** (`CONV_DATA_WIDTH - 1) - 1;
    localparam longint SAT_MIN = -(2 ** (`CONV_DATA_WIDTH - 1));

    logic          clk;
    logic          convRst;
    logic          start;
    layer_addr_t   in_base;
    layer_addr_t   out_base;
    logic          fm_rd_en;
    layer_addr_t   fm_rd_addr;
    data_t         fm_rd_data = '0;
    logic          wt_rd_en;
    weight_addr_t  wt_rd_addr;
    weight_slice_u wt_rd_data = '0;
    logic          bias_rd_en;
    weight_addr_t  bias_rd_addr;
    data_t         bias_rd_data = '0;
    logic          out_we;
    layer_addr_t   out_addr;
    data_t         out_data;
    logic          done;

    // memory images and request pipeline of the RAM models
    data_t        fm_img [FM_WORDS];
    data_t        wt_img [KC*D][K][K];
    data_t        bias_img [KC];
    layer_addr_t  fm_base = '0;
    logic         fm_pend = 1'b0;
    logic         wt_pend = 1'b0;
    logic         bias_pend = 1'b0;
    layer_addr_t  fm_addr_q;
    weight_addr_t wt_addr_q;
    weight_addr_t bias_addr_q;

    data_t        wr_data [$];   // captured out_data in write order
    layer_addr_t  wr_addr [$];
    int           last_we_cycle = 0;
    int           done_rise_cycle = 0;
    logic         done_prev = 1'b0;
    logic [31:0]  lfsr = 32'h4022;
    logic         done_after_start;
    logic         active_seen;
    int           cycle_cnt = 0;
    string        cur_test;
    int           test_errs;
    int           test_total = 0;
    int           tests_bad = 0;
    int           check_total = 0;

    conv_layer i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    initial begin : watchdog
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("timeout: layer did not finish within %0d cycles", CYCLE_LIMIT);
        $display("tests failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // RAM models with data one cycle after the read enable
    ////////////////////////////////////////////////////////////////////////////

    function automatic data_t read_layer(input layer_addr_t addr);
        layer_addr_t off;
        off = addr - fm_base;
        if (off < FM_WORDS)
            return fm_img[off];
        return data_t'(addr[15:0] ^ {13'd0, addr[18:16]});  // outside the input map
    endfunction

    // tap (r, c) at bits (r*K + c)*16 upward
    function automatic weight_slice_u slice_word(input weight_addr_t addr);
        weight_slice_u w;
        w.flat = {(K*K){6'd0, addr}};
        if (addr < KC * D)
            for (int r = 0; r < K; r++)
                for (int c = 0; c < K; c++)
                    w.flat[(r*K + c)*`CONV_DATA_WIDTH +: `CONV_DATA_WIDTH] = wt_img[addr][r][c];
        return w;
    endfunction

    always @(negedge clk) begin
        if (fm_pend)
            fm_rd_data = read_layer(fm_addr_q);
        if (wt_pend)
            wt_rd_data = slice_word(wt_addr_q);
        if (bias_pend)
            bias_rd_data = (bias_addr_q < KC) ? bias_img[bias_addr_q]
                                              : data_t'({6'd0, bias_addr_q});
        fm_pend     = fm_rd_en;
        fm_addr_q   = fm_rd_addr;
        wt_pend     = wt_rd_en;
        wt_addr_q   = wt_rd_addr;
        bias_pend   = bias_rd_en;
        bias_addr_q = bias_rd_addr;
    end

    always @(negedge clk) begin
        if (out_we) begin
            wr_addr.push_back(out_addr);
            wr_data.push_back(out_data);
            last_we_cycle = cycle_cnt;
        end
        if (done && !done_prev)
            done_rise_cycle = cycle_cnt;
        done_prev = done;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus and reference model
    ////////////////////////////////////////////////////////////////////////////

    // galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic data_t rand_signed(input int n);
        logic signed [31:0] s;
        s = rand_bits(n) << (32 - n);
        return data_t'(s >>> (32 - n));
    endfunction

    task automatic fill_layer(input bit saturate);
        for (int i = 0; i < FM_WORDS; i++)
            fm_img[i] = saturate ? data_t'(30000 + rand_bits(10)) : rand_signed(8);
        for (int s = 0; s < KC * D; s++)
            for (int r = 0; r < K; r++)
                for (int c = 0; c < K; c++)
                    if (!saturate)
                        wt_img[s][r][c] = rand_signed(5);
                    else if (s < D)
                        wt_img[s][r][c] = data_t'(20000 + rand_bits(10));  // kernel 0 up
                    else
                        wt_img[s][r][c] = data_t'(-20000 - int'(rand_bits(10)));
        for (int k = 0; k < KC; k++)
            bias_img[k] = rand_signed(12);
    endtask

    function automatic data_t expected_out(input int k, input int y, input int x);
        longint sum;
        int     pos;
        sum = bias_img[k];
        for (int d = 0; d < D; d++)
            for (int r = 0; r < K; r++)
                for (int c = 0; c < K; c++) begin
                    pos = d*FM*FM + (y*STRIDE + r)*FM + x*STRIDE + c;
                    sum += longint'(fm_img[pos]) * longint'(wt_img[k*D + d][r][c]);
                end
        if (sum > SAT_MAX)
            return data_t'(SAT_MAX);
        if (sum < SAT_MIN)
            return data_t'(SAT_MIN);
        return data_t'(sum);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // checks and report
    ////////////////////////////////////////////////////////////////////////////

    task automatic begin_test(input string name);
        cur_test  = name;
        test_errs = 0;
    endtask

    task automatic end_test();
        test_total++;
        if (test_errs != 0)
            tests_bad++;
        $display("test %s: %s (%0d errors)", cur_test, test_errs == 0 ? "ok" : "FAIL",
                 test_errs);
    endtask

    task automatic check_value(input string what, input longint expected, input longint actual);
        check_total++;
        assert (expected == actual) else begin
            $display("error %s %s: expected %0d actual %0d", cur_test, what, expected, actual);
            test_errs++;
        end
    endtask

    task automatic expect_true(input bit cond, input string msg);
        check_total++;
        assert (cond) else begin
            $display("%s: %s", cur_test, msg);
            test_errs++;
        end
    endtask

    task automatic compare_outputs(input bit saturate);
        int    n;
        data_t got;
        check_value("write count", OUT_TOTAL, wr_data.size());
        for (int k = 0; k < KC; k++)
            for (int y = 0; y < OUT; y++)
                for (int x = 0; x < OUT; x++) begin
                    n = (k*OUT + y)*OUT + x;   // kernel, y, x order
                    if (n < wr_data.size()) begin
                        got = wr_data[n];
                        check_value($sformatf("out %0d", n), expected_out(k, y, x), got);
                        if (saturate)
                            expect_true(got == data_t'(SAT_MAX) || got == data_t'(SAT_MIN),
                                        $sformatf("output %0d is not at a rail", n));
                    end
                end
    endtask

    task automatic compare_addresses(input layer_addr_t ob);
        check_value("write count", OUT_TOTAL, wr_addr.size());
        for (int n = 0; n < wr_addr.size(); n++)
            check_value($sformatf("addr %0d", n), longint'(layer_addr_t'(ob + n)),
                        longint'(wr_addr[n]));
    endtask

    task automatic start_layer(input layer_addr_t ib, input layer_addr_t ob);
        in_base  = ib;
        out_base = ob;
        fm_base  = ib;
        wr_addr.delete();
        wr_data.delete();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        done_after_start = done;
    endtask

    task automatic run_layer(input layer_addr_t ib, input layer_addr_t ob);
        start_layer(ib, ob);
        while (!done)
            @(negedge clk);   // watchdog bounds this
    endtask

    initial begin : main
        convRst  = 1'b1;
        start    = 1'b0;
        in_base  = '0;
        out_base = '0;
        repeat (8) @(negedge clk);
        convRst = 1'b0;
        @(negedge clk);

        fill_layer(1'b0);
        run_layer(19'h00100, 19'h04000);
        begin_test("random_layer");
        compare_outputs(1'b0);
        end_test();
        begin_test("write_order");
        compare_addresses(19'h04000);
        end_test();

        begin_test("status");
        repeat (4 * (K*K + 1)) @(negedge clk);
        check_value("done rise cycle", last_we_cycle + 1, done_rise_cycle);
        check_value("writes after done", OUT_TOTAL, wr_data.size());
        expect_true(done, "done dropped without a new start");
        end_test();

        begin_test("second_run");
        fill_layer(1'b0);
        run_layer(19'h2a000, 19'h7ff00);   // output block at the top of the map
        expect_true(!done_after_start, "done stayed high after the second start");
        compare_outputs(1'b0);
        compare_addresses(19'h7ff00);
        end_test();

        begin_test("saturation");
        fill_layer(1'b1);
        run_layer(19'h10000, 19'h00400);
        compare_outputs(1'b1);
        end_test();

        begin_test("reset_mid_run");
        fill_layer(1'b0);
        start_layer(19'h00000, 19'h01000);
        repeat (RUN_CYCLES / 3) @(negedge clk);
        expect_true(!done, "done was high in the middle of a run");
        convRst = 1'b1;
        repeat (2) @(negedge clk);
        convRst     = 1'b0;
        active_seen = 1'b0;
        repeat (20 * (K*K + 1)) begin
            @(negedge clk);
            active_seen |= out_we | fm_rd_en | wt_rd_en | bias_rd_en | done;
        end
        expect_true(!active_seen, "a write, read or done came up after reset with no start");
        end_test();

        $display("summary: %0d tests, %0d with errors, %0d checks", test_total, tests_bad,
                 check_total);
        if (tests_bad == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
